// File: Makefile
TOP := complete_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/complete_chk.sv
`timescale 1ns/100ps
`default_nettype none

module complete_chk (
    input wire                         clk,
    input wire                         rstn,
    input wire                         dm_req,
    input wire                         dm_ack,
    input wire [core_pkg::xlen-1:0]    dm_addr,
    input wire [core_pkg::xlen-1:0]    dm_data,
    input wire                         dm_byte,
    input wire                         cmp0_valid,
    input wire                         cmp1_valid,
    input wire                         cmp2_valid
);

    req_rise_ack_low: assert property (@(posedge clk) disable iff (!rstn)
        $rose(dm_req) |-> !dm_ack)
        else $error("dm_req rose while dm_ack was high");

    req_fields_stable: assert property (@(posedge clk) disable iff (!rstn)
        dm_req |=> !dm_req || ($stable(dm_addr) && $stable(dm_data) && $stable(dm_byte)))
        else $error("dm_addr, dm_data or dm_byte changed while dm_req was high");

    req_drops_on_ack: assert property (@(posedge clk) disable iff (!rstn)
        dm_req && dm_ack |=> !dm_req)
        else $error("dm_req still high one cycle after dm_ack");

    // the next request waits until the previous ack is gone.
    req_waits_ack_low: assert property (@(posedge clk) disable iff (!rstn)
        !dm_req && dm_ack |=> !dm_req)
        else $error("dm_req rose before dm_ack fell");

    reset_outputs_low: assert property (@(posedge clk)
        !rstn |-> !dm_req && !cmp0_valid && !cmp1_valid && !cmp2_valid)
        else $error("completion valid or dm_req high during reset");

endmodule

bind complete_top complete_chk u_chk (
    .clk        (clk),
    .rstn       (rstn),
    .dm_req     (dm_req),
    .dm_ack     (dm_ack),
    .dm_addr    (dm_addr),
    .dm_data    (dm_data),
    .dm_byte    (dm_byte),
    .cmp0_valid (cmp0_valid),
    .cmp1_valid (cmp1_valid),
    .cmp2_valid (cmp2_valid)
);

`default_nettype wire

// File: dv/complete_tb.sv
`timescale 1ns/100ps
`default_nettype none

module complete_tb;
    import core_pkg::*;
    import mem_pkg::*;

    logic            clk;
    logic            rstn;
    logic            issue0_valid;
    logic            issue1_valid;
    logic            issue2_valid;
    logic [xlen-1:0] issue0_pc, issue0_result, issue1_pc, issue1_result;
    logic [xlen-1:0] issue2_pc, issue2_result, issue2_store_data;
    reg_idx_t        issue0_dest, issue1_dest, issue2_dest;
    rob_tag_t        issue0_rob, issue1_rob, issue2_rob;
    optype_t         issue2_op;
    ld_src_t         ld_src;
    logic [xlen-1:0] lsq_data, cache_data, mem_data;
    logic            mem_ready;
    logic            dm_req, dm_byte, dm_ack;
    logic [xlen-1:0] dm_addr, dm_data;
    logic            cmp0_valid, cmp1_valid, cmp2_valid;
    logic [xlen-1:0] cmp0_pc, cmp0_data, cmp1_pc, cmp1_data, cmp2_pc, cmp2_data;
    reg_idx_t        cmp0_dest, cmp1_dest, cmp2_dest;
    rob_tag_t        cmp0_rob, cmp1_rob, cmp2_rob;

    integer          seed = 32'h8b45_4295;
    int              errors;
    int              timeouts;
    logic            resp_paused;

    // requests seen by data memory, and store completions seen on lane 2.
    logic [xlen-1:0] req_addr_q[$], req_data_q[$], st_pc_q[$], st_data_q[$];
    logic            req_byte_q[$];
    reg_idx_t        st_dest_q[$];
    rob_tag_t        st_rob_q[$];
    // stores the DUT accepted, in issue order.
    logic [xlen-1:0] exp_pc_q[$], exp_addr_q[$], exp_data_q[$];
    logic            exp_byte_q[$];
    rob_tag_t        exp_rob_q[$];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    complete_top #(
        .sb_depth (4)
    ) UUT (.*);

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic step();
        @(posedge clk);
        #2;  // inputs change and outputs are read here.
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] got, want);
        if (got !== want) begin
            $display("error: %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_rob(input string name, input rob_tag_t got, want);
        if (got !== want) begin
            $display("error: %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, want);
        if (got !== want) begin
            $display("error: %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, want);
        if (got !== want) begin
            $display("error: %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_lane(input int k, input logic valid, input logic [xlen-1:0] pc, want_pc,
                              input reg_idx_t dest, want_dest, input logic [xlen-1:0] data,
                              want_data, input rob_tag_t rob, want_rob);
        check_bit($sformatf("cmp%0d_valid", k), valid, 1'b1);
        check_word($sformatf("cmp%0d_pc", k), pc, want_pc);
        check_reg($sformatf("cmp%0d_dest", k), dest, want_dest);
        check_word($sformatf("cmp%0d_data", k), data, want_data);
        check_rob($sformatf("cmp%0d_rob", k), rob, want_rob);
    endtask

    // store completions use rob tags with bit 5 set and all other lane 2 work keeps it clear.
    initial begin
        forever begin
            step();
            if (cmp2_valid && cmp2_rob[5]) begin
                st_pc_q.push_back(cmp2_pc);
                st_dest_q.push_back(cmp2_dest);
                st_data_q.push_back(cmp2_data);
                st_rob_q.push_back(cmp2_rob);
            end
        end
    end

    // data memory model. Ack comes at least one cycle after req is seen.
    initial begin
        int delay;
        int guard;
        dm_ack = 1'b0;
        forever begin
            step();
            if (dm_req && !dm_ack && !resp_paused) begin
                req_addr_q.push_back(dm_addr);
                req_data_q.push_back(dm_data);
                req_byte_q.push_back(dm_byte);
                delay = int'(next_rand() % 4);
                repeat (delay + 1) step();
                dm_ack = 1'b1;
                guard = 0;
                while (dm_req && guard < 20) begin
                    step();
                    guard++;
                end
                if (dm_req) begin
                    $display("timeout: dm_req stayed high after dm_ack rose");
                    timeouts++;
                end
                dm_ack = 1'b0;
            end
        end
    end

    // holds the store on lane 2 until mem_ready lets it in.
    task automatic issue_store(input logic is_byte, input logic [xlen-1:0] pc, addr, data,
                               input rob_tag_t rob);
        int guard;
        issue2_valid      = 1'b1;
        issue2_op         = is_byte ? op_sb : op_sw;
        issue2_pc         = pc;
        issue2_result     = addr;
        issue2_store_data = data;
        issue2_dest       = '0;
        issue2_rob        = rob;
        guard = 0;
        while (!mem_ready && guard < 200) begin
            step();
            guard++;
        end
        if (!mem_ready) begin
            $display("timeout: mem_ready never rose for store rob %h", rob);
            timeouts++;
        end else begin
            exp_pc_q.push_back(pc);
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(data);
            exp_byte_q.push_back(is_byte);
            exp_rob_q.push_back(rob);
        end
        step();
        issue2_valid = 1'b0;
    endtask

    task automatic finish_stores();
        int guard;
        int n;
        n = exp_rob_q.size();
        guard = 0;
        while ((req_addr_q.size() < n || st_rob_q.size() < n) && guard < 400) begin
            step();
            guard++;
        end
        if (req_addr_q.size() < n || st_rob_q.size() < n) begin
            $display("timeout: stores still missing a request or a completion");
            timeouts++;
        end
        repeat (8) step();  // room for a duplicate to show up.
        if (req_addr_q.size() != n || st_rob_q.size() != n) begin
            $display("%0d stores accepted but %0d requests and %0d completions seen",
                     n, req_addr_q.size(), st_rob_q.size());
            errors++;
        end
        for (int i = 0; i < n && i < req_addr_q.size(); i++) begin
            check_word("dm_addr", req_addr_q[i], exp_addr_q[i]);
            check_word("dm_data", req_data_q[i], exp_data_q[i]);
            check_bit("dm_byte", req_byte_q[i], exp_byte_q[i]);
        end
        for (int i = 0; i < n && i < st_rob_q.size(); i++) begin
            check_word("cmp2_pc", st_pc_q[i], exp_pc_q[i]);
            check_reg("cmp2_dest", st_dest_q[i], '0);
            check_word("cmp2_data", st_data_q[i], '0);
            check_rob("cmp2_rob", st_rob_q[i], exp_rob_q[i]);
        end
        req_addr_q.delete();
        req_data_q.delete();
        req_byte_q.delete();
        st_pc_q.delete();
        st_dest_q.delete();
        st_data_q.delete();
        st_rob_q.delete();
        exp_pc_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_byte_q.delete();
        exp_rob_q.delete();
    endtask

    task automatic reset_state_test();
        check_bit("cmp0_valid", cmp0_valid, 1'b0);
        check_bit("cmp1_valid", cmp1_valid, 1'b0);
        check_bit("cmp2_valid", cmp2_valid, 1'b0);
        check_bit("dm_req", dm_req, 1'b0);
        check_bit("mem_ready", mem_ready, 1'b1);
    endtask

    task automatic alu_lanes_test();
        issue2_op = op_alu;
        for (int i = 0; i < 8; i++) begin
            {issue0_valid, issue1_valid, issue2_valid} = 3'b111;
            {issue0_pc, issue1_pc, issue2_pc} = {next_rand(), next_rand(), next_rand()};
            {issue0_result, issue1_result, issue2_result} = {next_rand(), next_rand(), next_rand()};
            {issue0_dest, issue1_dest, issue2_dest} = 18'(next_rand());
            {issue0_rob, issue1_rob, issue2_rob} = 18'(next_rand()) & 18'h3ffdf;
            step();
            check_lane(0, cmp0_valid, cmp0_pc, issue0_pc, cmp0_dest, issue0_dest,
                       cmp0_data, issue0_result, cmp0_rob, issue0_rob);
            check_lane(1, cmp1_valid, cmp1_pc, issue1_pc, cmp1_dest, issue1_dest,
                       cmp1_data, issue1_result, cmp1_rob, issue1_rob);
            check_lane(2, cmp2_valid, cmp2_pc, issue2_pc, cmp2_dest, issue2_dest,
                       cmp2_data, issue2_result, cmp2_rob, issue2_rob);
        end
        {issue0_valid, issue1_valid, issue2_valid} = 3'b000;
    endtask

    task automatic load_test();
        logic [xlen-1:0] word;
        logic [7:0]      lb_byte;
        logic [xlen-1:0] want;
        issue2_valid = 1'b1;
        for (int s = 0; s < 3; s++) begin
            for (int a = 0; a < 4; a++) begin
                for (int b = 0; b < 2; b++) begin
                    ld_src        = ld_src_t'(s);
                    issue2_op     = (b == 1) ? op_lb : op_lw;
                    issue2_pc     = next_rand();
                    issue2_result = (next_rand() & ~32'h3) | 32'(a);
                    issue2_dest   = reg_idx_t'(next_rand());
                    issue2_rob    = rob_tag_t'(next_rand() % 32);
                    {lsq_data, cache_data, mem_data} = {next_rand(), next_rand(), next_rand()};
                    word    = (s == 0) ? lsq_data : ((s == 1) ? cache_data : mem_data);
                    lb_byte = word[8*a +: 8];
                    want    = (b == 1) ? {{24{lb_byte[7]}}, lb_byte} : word;
                    step();
                    check_lane(2, cmp2_valid, cmp2_pc, issue2_pc, cmp2_dest, issue2_dest,
                               cmp2_data, want, cmp2_rob, issue2_rob);
                end
            end
        end
        issue2_valid = 1'b0;
    endtask

    task automatic store_test();
        for (int i = 0; i < 6; i++) begin
            issue_store(i[0], next_rand(), next_rand(), next_rand(), rob_tag_t'(32 + i));
        end
        finish_stores();
    endtask

    task automatic backpressure_test();
        resp_paused = 1'b1;
        for (int i = 0; i < 4; i++) begin
            issue_store(i[0], next_rand(), next_rand(), next_rand(), rob_tag_t'(40 + i));
        end
        check_bit("mem_ready", mem_ready, 1'b0);
        fork
            issue_store(1'b1, next_rand(), next_rand(), next_rand(), rob_tag_t'(44));
            begin
                repeat (6) step();
                check_bit("mem_ready", mem_ready, 1'b0);  // fifth store still held.
                resp_paused = 1'b0;
            end
        join
        finish_stores();
    endtask

    // lane 2 stays busy with alu work while the stores wait for a free slot.
    task automatic contention_test();
        for (int i = 0; i < 3; i++) begin
            issue_store(i[0], next_rand(), next_rand(), next_rand(), rob_tag_t'(48 + i));
        end
        issue2_valid = 1'b1;
        issue2_op    = op_alu;
        for (int i = 0; i < 16; i++) begin
            issue2_pc     = next_rand();
            issue2_result = next_rand();
            issue2_dest   = reg_idx_t'(next_rand());
            issue2_rob    = rob_tag_t'(next_rand() % 32);
            step();
            check_lane(2, cmp2_valid, cmp2_pc, issue2_pc, cmp2_dest, issue2_dest,
                       cmp2_data, issue2_result, cmp2_rob, issue2_rob);
        end
        issue2_valid = 1'b0;
        finish_stores();
    endtask

    initial begin
        rstn        = 1'b0;
        resp_paused = 1'b0;
        errors      = 0;
        timeouts    = 0;
        {issue0_valid, issue1_valid, issue2_valid} = 3'b000;
        {issue0_pc, issue0_result, issue1_pc, issue1_result} = '0;
        {issue2_pc, issue2_result, issue2_store_data} = '0;
        {issue0_dest, issue1_dest, issue2_dest, issue0_rob, issue1_rob, issue2_rob} = '0;
        {lsq_data, cache_data, mem_data} = '0;
        issue2_op = op_alu;
        ld_src    = ld_fwd;
        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;
        step();
        reset_state_test();
        alu_lanes_test();
        load_test();
        store_test();
        backpressure_test();
        contention_test();
        $display("run complete with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/complete_reg.sv
`timescale 1ns/100ps
`default_nettype none

module complete_reg (
    input  wire                         clk,
    input  wire                         rstn,

    input  wire                         issue0_valid,
    input  wire [core_pkg::xlen-1:0]    issue0_pc,
    input  wire [core_pkg::xlen-1:0]    issue0_result,
    input  wire core_pkg::reg_idx_t     issue0_dest,
    input  wire core_pkg::rob_tag_t     issue0_rob,

    input  wire                         issue1_valid,
    input  wire [core_pkg::xlen-1:0]    issue1_pc,
    input  wire [core_pkg::xlen-1:0]    issue1_result,
    input  wire core_pkg::reg_idx_t     issue1_dest,
    input  wire core_pkg::rob_tag_t     issue1_rob,

    input  wire                         issue2_valid,
    input  wire core_pkg::optype_t      issue2_op,
    input  wire [core_pkg::xlen-1:0]    issue2_pc,
    input  wire [core_pkg::xlen-1:0]    issue2_result,
    input  wire core_pkg::reg_idx_t     issue2_dest,
    input  wire core_pkg::rob_tag_t     issue2_rob,

    input  wire [core_pkg::xlen-1:0]    load_data,

    input  wire                         done_valid,
    input  wire [core_pkg::xlen-1:0]    done_pc,
    input  wire core_pkg::rob_tag_t     done_rob,
    output logic                        done_take,

    output logic                        cmp0_valid,
    output logic [core_pkg::xlen-1:0]   cmp0_pc,
    output core_pkg::reg_idx_t          cmp0_dest,
    output logic [core_pkg::xlen-1:0]   cmp0_data,
    output core_pkg::rob_tag_t          cmp0_rob,

    output logic                        cmp1_valid,
    output logic [core_pkg::xlen-1:0]   cmp1_pc,
    output core_pkg::reg_idx_t          cmp1_dest,
    output logic [core_pkg::xlen-1:0]   cmp1_data,
    output core_pkg::rob_tag_t          cmp1_rob,

    output logic                        cmp2_valid,
    output logic [core_pkg::xlen-1:0]   cmp2_pc,
    output core_pkg::reg_idx_t          cmp2_dest,
    output logic [core_pkg::xlen-1:0]   cmp2_data,
    output core_pkg::rob_tag_t          cmp2_rob
);
    import core_pkg::*;

    logic issue2_store;
    logic issue2_load;
    logic issue2_takes;

    assign issue2_store = (issue2_op == op_sb) || (issue2_op == op_sw);
    assign issue2_load  = (issue2_op == op_lb) || (issue2_op == op_lw);
    assign issue2_takes = issue2_valid && !issue2_store;  // a store completes later, from the buffer.

    // a store completion only gets lane 2 when no load or alu result needs it.
    assign done_take = done_valid && !issue2_takes;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cmp0_valid <= 1'b0;
            cmp0_pc    <= '0;
            cmp0_dest  <= '0;
            cmp0_data  <= '0;
            cmp0_rob   <= '0;
            cmp1_valid <= 1'b0;
            cmp1_pc    <= '0;
            cmp1_dest  <= '0;
            cmp1_data  <= '0;
            cmp1_rob   <= '0;
        end else begin
            cmp0_valid <= issue0_valid;
            cmp0_pc    <= issue0_pc;
            cmp0_dest  <= issue0_dest;
            cmp0_data  <= issue0_result;
            cmp0_rob   <= issue0_rob;
            cmp1_valid <= issue1_valid;
            cmp1_pc    <= issue1_pc;
            cmp1_dest  <= issue1_dest;
            cmp1_data  <= issue1_result;
            cmp1_rob   <= issue1_rob;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cmp2_valid <= 1'b0;
            cmp2_pc    <= '0;
            cmp2_dest  <= '0;
            cmp2_data  <= '0;
            cmp2_rob   <= '0;
        end else begin
            cmp2_valid <= issue2_takes || done_valid;
            if (issue2_takes) begin
                cmp2_pc   <= issue2_pc;
                cmp2_dest <= issue2_dest;
                cmp2_data <= issue2_load ? load_data : issue2_result;
                cmp2_rob  <= issue2_rob;
            end else if (done_valid) begin
                cmp2_pc   <= done_pc;
                cmp2_dest <= '0;  // stores write no register.
                cmp2_data <= '0;
                cmp2_rob  <= done_rob;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/complete_top.sv
`timescale 1ns/100ps
`default_nettype none

module complete_top #(
    parameter int sb_depth = mem_pkg::sb_depth_default
) (
    input  wire                         clk,
    input  wire                         rstn,

    input  wire                         issue0_valid,
    input  wire [core_pkg::xlen-1:0]    issue0_pc,
    input  wire [core_pkg::xlen-1:0]    issue0_result,
    input  wire core_pkg::reg_idx_t     issue0_dest,
    input  wire core_pkg::rob_tag_t     issue0_rob,

    input  wire                         issue1_valid,
    input  wire [core_pkg::xlen-1:0]    issue1_pc,
    input  wire [core_pkg::xlen-1:0]    issue1_result,
    input  wire core_pkg::reg_idx_t     issue1_dest,
    input  wire core_pkg::rob_tag_t     issue1_rob,

    input  wire                         issue2_valid,
    input  wire core_pkg::optype_t      issue2_op,
    input  wire [core_pkg::xlen-1:0]    issue2_pc,
    input  wire [core_pkg::xlen-1:0]    issue2_result,
    input  wire core_pkg::reg_idx_t     issue2_dest,
    input  wire core_pkg::rob_tag_t     issue2_rob,
    input  wire [core_pkg::xlen-1:0]    issue2_store_data,

    input  wire mem_pkg::ld_src_t       ld_src,
    input  wire [core_pkg::xlen-1:0]    lsq_data,
    input  wire [core_pkg::xlen-1:0]    cache_data,
    input  wire [core_pkg::xlen-1:0]    mem_data,
    output logic                        mem_ready,

    output logic                        dm_req,
    output logic [core_pkg::xlen-1:0]   dm_addr,
    output logic [core_pkg::xlen-1:0]   dm_data,
    output logic                        dm_byte,
    input  wire                         dm_ack,

    output logic                        cmp0_valid,
    output logic [core_pkg::xlen-1:0]   cmp0_pc,
    output core_pkg::reg_idx_t          cmp0_dest,
    output logic [core_pkg::xlen-1:0]   cmp0_data,
    output core_pkg::rob_tag_t          cmp0_rob,

    output logic                        cmp1_valid,
    output logic [core_pkg::xlen-1:0]   cmp1_pc,
    output core_pkg::reg_idx_t          cmp1_dest,
    output logic [core_pkg::xlen-1:0]   cmp1_data,
    output core_pkg::rob_tag_t          cmp1_rob,

    output logic                        cmp2_valid,
    output logic [core_pkg::xlen-1:0]   cmp2_pc,
    output core_pkg::reg_idx_t          cmp2_dest,
    output logic [core_pkg::xlen-1:0]   cmp2_data,
    output core_pkg::rob_tag_t          cmp2_rob
);
    import core_pkg::*;

    logic [xlen-1:0] load_data;
    logic            sb_push;
    logic            done_valid;
    logic [xlen-1:0] done_pc;
    rob_tag_t        done_rob;
    logic            done_take;

    // a store shown while the buffer is full is simply not taken.
    assign sb_push = issue2_valid && ((issue2_op == op_sb) || (issue2_op == op_sw)) && mem_ready;

    load_result_mux u_load_mux (
        .op         (issue2_op),
        .addr_lo    (issue2_result[1:0]),
        .ld_src     (ld_src),
        .lsq_data   (lsq_data),
        .cache_data (cache_data),
        .mem_data   (mem_data),
        .load_data  (load_data)
    );

    store_buffer #(
        .sb_depth (sb_depth)
    ) u_store_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .push       (sb_push),
        .push_pc    (issue2_pc),
        .push_rob   (issue2_rob),
        .push_addr  (issue2_result),  // memory ops carry the byte address here.
        .push_data  (issue2_store_data),
        .push_byte  (issue2_op == op_sb),
        .ready      (mem_ready),
        .dm_req     (dm_req),
        .dm_addr    (dm_addr),
        .dm_data    (dm_data),
        .dm_byte    (dm_byte),
        .dm_ack     (dm_ack),
        .done_valid (done_valid),
        .done_pc    (done_pc),
        .done_rob   (done_rob),
        .done_take  (done_take)
    );

    complete_reg u_complete_reg (
        .clk           (clk),
        .rstn          (rstn),
        .issue0_valid  (issue0_valid),
        .issue0_pc     (issue0_pc),
        .issue0_result (issue0_result),
        .issue0_dest   (issue0_dest),
        .issue0_rob    (issue0_rob),
        .issue1_valid  (issue1_valid),
        .issue1_pc     (issue1_pc),
        .issue1_result (issue1_result),
        .issue1_dest   (issue1_dest),
        .issue1_rob    (issue1_rob),
        .issue2_valid  (issue2_valid),
        .issue2_op     (issue2_op),
        .issue2_pc     (issue2_pc),
        .issue2_result (issue2_result),
        .issue2_dest   (issue2_dest),
        .issue2_rob    (issue2_rob),
        .load_data     (load_data),
        .done_valid    (done_valid),
        .done_pc       (done_pc),
        .done_rob      (done_rob),
        .done_take     (done_take),
        .cmp0_valid    (cmp0_valid),
        .cmp0_pc       (cmp0_pc),
        .cmp0_dest     (cmp0_dest),
        .cmp0_data     (cmp0_data),
        .cmp0_rob      (cmp0_rob),
        .cmp1_valid    (cmp1_valid),
        .cmp1_pc       (cmp1_pc),
        .cmp1_dest     (cmp1_dest),
        .cmp1_data     (cmp1_data),
        .cmp1_rob      (cmp1_rob),
        .cmp2_valid    (cmp2_valid),
        .cmp2_pc       (cmp2_pc),
        .cmp2_dest     (cmp2_dest),
        .cmp2_data     (cmp2_data),
        .cmp2_rob      (cmp2_rob)
    );

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 32;  // data and pc width.

    typedef logic [5:0] rob_tag_t;

    // physical register 0 means the operation writes no register.
    typedef logic [5:0] reg_idx_t;

    // lane 2 operations, encoded as the issue stage sends them.
    typedef enum logic [3:0] {
        op_alu = 4'd0,
        op_lb  = 4'd7,
        op_lw  = 4'd8,
        op_sb  = 4'd9,
        op_sw  = 4'd10
    } optype_t;

endpackage

`default_nettype wire

// File: hdl/load_result_mux.sv
`timescale 1ns/100ps
`default_nettype none

module load_result_mux (
    input  wire core_pkg::optype_t      op,
    input  wire [1:0]                   addr_lo,
    input  wire mem_pkg::ld_src_t       ld_src,
    input  wire [core_pkg::xlen-1:0]    lsq_data,
    input  wire [core_pkg::xlen-1:0]    cache_data,
    input  wire [core_pkg::xlen-1:0]    mem_data,
    output logic [core_pkg::xlen-1:0]   load_data
);
    import core_pkg::*;
    import mem_pkg::*;

    logic [xlen-1:0] src_word;
    logic [7:0]      lb_byte;

    always_comb begin
        case (ld_src)
            ld_fwd:   src_word = lsq_data;
            ld_cache: src_word = cache_data;
            default:  src_word = mem_data;  // ld_mem.
        endcase
    end

    // byte 0 is the low byte of the word.
    assign lb_byte = src_word[{addr_lo, 3'b000} +: 8];

    assign load_data = (op == op_lb) ? {{(xlen - 8){lb_byte[7]}}, lb_byte} : src_word;

endmodule

`default_nettype wire

// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // where the data of a load comes from.
    typedef enum logic [1:0] {
        ld_fwd   = 2'd0,  // forwarded by the load/store queue.
        ld_cache = 2'd1,  // cache hit.
        ld_mem   = 2'd2   // cache miss, read from data memory.
    } ld_src_t;

    localparam int sb_depth_default = 8;  // pending stores held before back-pressure.

endpackage

`default_nettype wire

// File: hdl/store_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module store_buffer #(
    parameter int sb_depth = mem_pkg::sb_depth_default
) (
    input  wire                         clk,
    input  wire                         rstn,

    input  wire                         push,
    input  wire [core_pkg::xlen-1:0]    push_pc,
    input  wire core_pkg::rob_tag_t     push_rob,
    input  wire [core_pkg::xlen-1:0]    push_addr,
    input  wire [core_pkg::xlen-1:0]    push_data,
    input  wire                         push_byte,
    output logic                        ready,

    output logic                        dm_req,
    output logic [core_pkg::xlen-1:0]   dm_addr,
    output logic [core_pkg::xlen-1:0]   dm_data,
    output logic                        dm_byte,
    input  wire                         dm_ack,

    output logic                        done_valid,
    output logic [core_pkg::xlen-1:0]   done_pc,
    output core_pkg::rob_tag_t          done_rob,
    input  wire                         done_take
);
    import core_pkg::*;

    localparam int aw = (sb_depth > 1) ? $clog2(sb_depth) : 1;
    localparam int cw = $clog2(sb_depth + 1);

    // the head entry goes through these states once, from request to completion.
    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_ack_low,
        st_done
    } state_t;

    state_t          state;
    logic [aw-1:0]   head;
    logic [aw-1:0]   tail;
    logic [cw-1:0]   count;
    logic            pop;

    logic [xlen-1:0] slot_pc   [sb_depth];
    rob_tag_t        slot_rob  [sb_depth];
    logic [xlen-1:0] slot_addr [sb_depth];
    logic [xlen-1:0] slot_data [sb_depth];
    logic            slot_byte [sb_depth];

    function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
        logic [aw-1:0] nxt;
        if (ptr == aw'(sb_depth - 1)) begin
            nxt = '0;  // wrap by compare because the depth need not be a power of two.
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign ready = (count != cw'(sb_depth));
    assign pop   = (state == st_done) && done_take;

    always_ff @(posedge clk) begin
        if (push) begin
            slot_pc[tail]   <= push_pc;
            slot_rob[tail]  <= push_rob;
            slot_addr[tail] <= push_addr;
            slot_data[tail] <= push_data;
            slot_byte[tail] <= push_byte;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    // a new request only starts once the previous ack is gone.
                    if ((count != '0) && !dm_ack) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (dm_ack) begin
                        state <= st_ack_low;
                    end
                end
                st_ack_low: begin
                    if (!dm_ack) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    if (done_take) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // the head slot is never written while it is in use, so these stay stable.
    assign dm_req  = (state == st_req);
    assign dm_addr = slot_addr[head];
    assign dm_data = slot_data[head];
    assign dm_byte = slot_byte[head];

    assign done_valid = (state == st_done);
    assign done_pc    = slot_pc[head];
    assign done_rob   = slot_rob[head];

endmodule

`default_nettype wire

// File: list.f
hdl/core_pkg.sv
hdl/mem_pkg.sv
hdl/load_result_mux.sv
hdl/store_buffer.sv
hdl/complete_reg.sv
hdl/complete_top.sv
dv/complete_chk.sv
dv/complete_tb.sv
